//--- neo_dl_pkg.sv
`default_nettype none

package neo_dl_pkg;

	// Cartridge regions in .NEO file order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} region_e;

	typedef logic [31:0] size_t;

	localparam int HEADER_BYTES     = 4096;
	localparam int SIZE_FIELD_FIRST = 4;  // PSize low byte
	localparam int SIZE_FIELD_LAST  = 27; // CSize high byte

	localparam int PAGE_BYTES = 128;

	localparam int ADDR_W      = 27; // Byte address
	localparam int WORD_ADDR_W = 25; // Port 2, banks 0-2
	localparam int P1_ADDR_W   = 23; // Port 1, bank 3

	// Bank 3 placement of the small ROMs
	localparam logic [4:0] FIX_PREFIX  = 5'b11100;
	localparam logic [4:0] MROM_PREFIX = 5'b11110;

endpackage

`default_nettype wire

//--- neo_header_parser.sv
`timescale 1ns/1ns
`default_nettype none

module neo_header_parser #(
	parameter int ADDR_W = 27
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic [7:0]          byte_i,
	input  logic                byte_valid_i,
	output logic                byte_ready_o,
	input  logic                download_i,
	input  logic                skip_adpcm_i,
	output logic [7:0]          b_data_o,
	output logic                b_valid_o,
	input  logic                b_ready_i,
	output neo_dl_pkg::region_e b_region_o,
	output logic [ADDR_W-1:0]   b_offset_o,
	output neo_dl_pkg::size_t   csize_o,
	output neo_dl_pkg::size_t   v1size_o,
	output neo_dl_pkg::size_t   c_mask_o,
	output neo_dl_pkg::size_t   v1_mask_o,
	output neo_dl_pkg::size_t   v2_mask_o,
	output neo_dl_pkg::size_t   p2_mask_o,
	output logic                pcm_merged_o
);

	logic [ADDR_W-1:0]   byte_addr_q;
	logic [ADDR_W-1:0]   offset_q;
	neo_dl_pkg::region_e region_q;
	neo_dl_pkg::size_t   psize_q, ssize_q, msize_q, v1size_q, v2size_q, csize_q;
	neo_dl_pkg::size_t   cur_size;
	logic [5:0]          nonzero;
	logic                accept, in_header, data_byte, drop_byte, region_end;

	// Next power of two minus one and zero for an empty region
	function automatic neo_dl_pkg::size_t pow2_mask(input neo_dl_pkg::size_t size);
		neo_dl_pkg::size_t m;
		m = size - 1'b1;
		m = m | (m >> 1);
		m = m | (m >> 2);
		m = m | (m >> 4);
		m = m | (m >> 8);
		m = m | (m >> 16);
		if (size == '0)
			m = '0;
		return m;
	endfunction

	function automatic neo_dl_pkg::region_e first_region(input logic [2:0] start,
		input logic [5:0] nz);
		neo_dl_pkg::region_e r;
		r = neo_dl_pkg::REG_DONE;
		for (int i = 5; i >= 0; i--) begin
			if (i >= start && nz[i])
				r = neo_dl_pkg::region_e'(3'(i));
		end
		return r;
	endfunction

	assign nonzero = {csize_q != '0, v2size_q != '0, v1size_q != '0,
		msize_q != '0, ssize_q != '0, psize_q != '0};

	always_comb begin
		case (region_q)
			neo_dl_pkg::REG_P:  cur_size = psize_q;
			neo_dl_pkg::REG_S:  cur_size = ssize_q;
			neo_dl_pkg::REG_M:  cur_size = msize_q;
			neo_dl_pkg::REG_V1: cur_size = v1size_q;
			neo_dl_pkg::REG_V2: cur_size = v2size_q;
			neo_dl_pkg::REG_C:  cur_size = csize_q;
			default:            cur_size = '0;
		endcase
	end

	assign byte_ready_o = !b_valid_o || b_ready_i; // One stage skid-free pipe
	assign accept       = download_i && byte_valid_i && byte_ready_o;
	assign in_header    = byte_addr_q < ADDR_W'(neo_dl_pkg::HEADER_BYTES);
	assign data_byte    = accept && !in_header && region_q != neo_dl_pkg::REG_DONE;
	assign drop_byte    = skip_adpcm_i &&
		(region_q == neo_dl_pkg::REG_V1 || region_q == neo_dl_pkg::REG_V2);
	assign region_end   = (offset_q + 1'b1) == cur_size[ADDR_W-1:0];

	assign csize_o  = csize_q;
	assign v1size_o = v1size_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			byte_addr_q  <= '0;
			offset_q     <= '0;
			region_q     <= neo_dl_pkg::REG_P;
			{csize_q, v2size_q, v1size_q, msize_q, ssize_q, psize_q} <= '0;
			c_mask_o     <= '0;
			v1_mask_o    <= '0;
			v2_mask_o    <= '0;
			p2_mask_o    <= '0;
			pcm_merged_o <= 1'b0;
			b_valid_o    <= 1'b0;
		end else begin
			if (b_ready_i)
				b_valid_o <= 1'b0;
			if (!download_i) begin
				byte_addr_q <= '0;
				offset_q    <= '0;
				region_q    <= neo_dl_pkg::REG_P;
			end else if (accept) begin
				byte_addr_q <= byte_addr_q + 1'b1;
				// Little-endian sizes shift in from the top
				if (byte_addr_q >= ADDR_W'(neo_dl_pkg::SIZE_FIELD_FIRST) &&
					byte_addr_q <= ADDR_W'(neo_dl_pkg::SIZE_FIELD_LAST)) begin
					{csize_q, v2size_q, v1size_q, msize_q, ssize_q, psize_q} <=
						{byte_i, csize_q, v2size_q, v1size_q, msize_q, ssize_q, psize_q[31:8]};
				end
				if (byte_addr_q == ADDR_W'(neo_dl_pkg::HEADER_BYTES - 1)) begin
					c_mask_o     <= pow2_mask(csize_q);
					v1_mask_o    <= pow2_mask(v1size_q);
					v2_mask_o    <= pow2_mask(v2size_q);
					p2_mask_o    <= (psize_q > 32'h0010_0000) ?
						pow2_mask(psize_q - 32'h0010_0000) : '0;
					pcm_merged_o <= v2size_q == '0; // Merged ADPCM-A/B image
					region_q     <= first_region(3'd0, nonzero);
					offset_q     <= '0;
				end
				if (data_byte) begin
					if (!drop_byte)
						b_valid_o <= 1'b1;
					if (region_end) begin
						offset_q <= '0;
						region_q <= first_region(region_q + 3'd1, nonzero);
					end else begin
						offset_q <= offset_q + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (data_byte && !drop_byte) begin
			b_data_o   <= byte_i;
			b_region_o <= region_q;
			b_offset_o <= offset_q;
		end
	end

	// Region walk only moves forward and never passes DONE
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		download_i |=> (region_q >= $past(region_q) &&
			region_q <= neo_dl_pkg::REG_DONE));

endmodule

`default_nettype wire

//--- neo_tile_shuffler.sv
`timescale 1ns/1ns
`default_nettype none

module neo_tile_shuffler #(
	parameter int ADDR_W     = 27,
	parameter int PAGE_BYTES = 128
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic [7:0]          b_data_i,
	input  logic                b_valid_i,
	output logic                b_ready_o,
	input  neo_dl_pkg::region_e b_region_i,
	input  logic [ADDR_W-1:0]   b_offset_i,
	output logic [15:0]         w_data_o,
	output logic                w_valid_o,
	input  logic                w_ready_i,
	output neo_dl_pkg::region_e w_region_o,
	output logic [ADDR_W-1:0]   w_offset_o
);

	localparam int PAGE_AW = $clog2(PAGE_BYTES);

	logic [7:0]                 page_mem [2*PAGE_BYTES]; // Two pages, byte wide
	logic [1:0]                 full_q;
	logic                       wr_page_q;
	logic                       rd_page_q;
	logic [PAGE_AW-2:0]         rd_idx_q;
	neo_dl_pkg::region_e        page_region_q [2];
	logic [ADDR_W-PAGE_AW-1:0]  page_base_q [2];
	logic [PAGE_AW-1:0]         wr_pos;
	logic                       wr_en, last_byte, rd_fire, last_word;

	// Tile byte order inside a page
	always_comb begin
		wr_pos = b_offset_i[PAGE_AW-1:0];
		case (b_region_i)
			neo_dl_pkg::REG_S:
				wr_pos[6:0] = {b_offset_i[6:5], b_offset_i[2:0], ~b_offset_i[4], b_offset_i[3]};
			neo_dl_pkg::REG_C:
				wr_pos[6:0] = {b_offset_i[5:2], ~b_offset_i[6], b_offset_i[0], b_offset_i[1]};
			default: ;
		endcase
	end

	assign b_ready_o = !full_q[wr_page_q]; // Stall while the next page still drains
	assign wr_en     = b_valid_i && b_ready_o;
	assign last_byte = &b_offset_i[PAGE_AW-1:0];

	assign w_valid_o = full_q[rd_page_q];
	assign rd_fire   = w_valid_o && w_ready_i;
	assign last_word = &rd_idx_q;

	// Little-endian word out of the draining page
	assign w_data_o   = {page_mem[{rd_page_q, rd_idx_q, 1'b1}],
		page_mem[{rd_page_q, rd_idx_q, 1'b0}]};
	assign w_region_o = page_region_q[rd_page_q];
	assign w_offset_o = {page_base_q[rd_page_q], rd_idx_q, 1'b0};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			full_q    <= '0;
			wr_page_q <= 1'b0;
			rd_page_q <= 1'b0;
			rd_idx_q  <= '0;
		end else begin
			if (wr_en && last_byte) begin
				full_q[wr_page_q] <= 1'b1;
				wr_page_q         <= ~wr_page_q;
			end
			if (rd_fire) begin
				rd_idx_q <= rd_idx_q + 1'b1;
				if (last_word) begin
					full_q[rd_page_q] <= 1'b0;
					rd_page_q         <= ~rd_page_q;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en)
			page_mem[{wr_page_q, wr_pos}] <= b_data_i;
		if (wr_en && last_byte) begin
			page_region_q[wr_page_q] <= b_region_i;
			page_base_q[wr_page_q]   <= b_offset_i[ADDR_W-1:PAGE_AW];
		end
	end

	// Draining page is never written, so an offered word holds until taken
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(w_valid_o && !w_ready_i) |=>
			(w_valid_o && $stable(w_data_o) && $stable(w_offset_o)));

	// Completed page is offered on the following cycle
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(wr_en && last_byte) |=> w_valid_o);

endmodule

`default_nettype wire

//--- neo_sdram_mapper.sv
`timescale 1ns/1ns
`default_nettype none

module neo_sdram_mapper #(
	parameter int ADDR_W = 27
) (
	input  logic                                 clk_i,
	input  logic                                 rst_ni,
	input  logic [15:0]                          w_data_i,
	input  logic                                 w_valid_i,
	output logic                                 w_ready_o,
	input  neo_dl_pkg::region_e                  w_region_i,
	input  logic [ADDR_W-1:0]                    w_offset_i,
	input  neo_dl_pkg::size_t                    csize_i,
	input  neo_dl_pkg::size_t                    v1size_i,
	output logic                                 p1_req_o,
	input  logic                                 p1_ack_i,
	output logic [neo_dl_pkg::P1_ADDR_W-1:0]     p1_addr_o,
	output logic [15:0]                          p1_data_o,
	output logic                                 p2_req_o,
	input  logic                                 p2_ack_i,
	output logic [neo_dl_pkg::WORD_ADDR_W-1:0]   p2_addr_o,
	output logic [15:0]                          p2_data_o
);

	logic              busy_q;
	logic              sel_p2_q;
	logic              to_p2, accept, done;
	logic [ADDR_W-1:0] byte_addr;

	// Bank 3 on port 1, banks 0-2 (C, V1, V2) on port 2
	always_comb begin
		to_p2     = 1'b0;
		byte_addr = w_offset_i;
		case (w_region_i)
			neo_dl_pkg::REG_S:
				byte_addr = ADDR_W'({neo_dl_pkg::FIX_PREFIX, w_offset_i[18:0]});
			neo_dl_pkg::REG_M:
				byte_addr = ADDR_W'({neo_dl_pkg::MROM_PREFIX, w_offset_i[18:0]});
			neo_dl_pkg::REG_C:
				to_p2 = 1'b1;
			neo_dl_pkg::REG_V1: begin
				to_p2     = 1'b1;
				byte_addr = csize_i[ADDR_W-1:0] + w_offset_i; // Right after sprites
			end
			neo_dl_pkg::REG_V2: begin
				to_p2     = 1'b1;
				byte_addr = csize_i[ADDR_W-1:0] + v1size_i[ADDR_W-1:0] + w_offset_i;
			end
			default: ;
		endcase
	end

	assign w_ready_o = !busy_q; // Single write in flight
	assign accept    = w_valid_i && w_ready_o;
	assign done      = sel_p2_q ? (p2_req_o == p2_ack_i) : (p1_req_o == p1_ack_i);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			busy_q   <= 1'b0;
			sel_p2_q <= 1'b0;
			p1_req_o <= 1'b0;
			p2_req_o <= 1'b0;
		end else begin
			if (accept) begin
				busy_q   <= 1'b1;
				sel_p2_q <= to_p2;
				if (to_p2)
					p2_req_o <= ~p2_req_o;
				else
					p1_req_o <= ~p1_req_o;
			end else if (busy_q && done) begin
				busy_q <= 1'b0;
			end
		end
	end

	// Held stable until the port acknowledges
	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (to_p2) begin
				p2_addr_o <= byte_addr[neo_dl_pkg::WORD_ADDR_W:1];
				p2_data_o <= w_data_i;
			end else begin
				p1_addr_o <= byte_addr[neo_dl_pkg::P1_ADDR_W:1];
				p1_data_o <= w_data_i;
			end
		end
	end

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(p1_req_o != p1_ack_i) |=> $stable(p1_req_o));

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(p2_req_o != p2_ack_i) |=> $stable(p2_req_o));

endmodule

`default_nettype wire

//--- neo_cart_loader.sv
`timescale 1ns/1ns
`default_nettype none

module neo_cart_loader #(
	parameter int ADDR_W     = neo_dl_pkg::ADDR_W,
	parameter int PAGE_BYTES = neo_dl_pkg::PAGE_BYTES
) (
	input  logic                                 clk_i,  // CLK_48M
	input  logic                                 rst_ni, // pll_locked
	input  logic [7:0]                           byte_i,
	input  logic                                 byte_valid_i,
	output logic                                 byte_ready_o,
	input  logic                                 download_i,
	input  logic                                 skip_adpcm_i,
	output logic                                 p1_req_o,
	input  logic                                 p1_ack_i,
	output logic [neo_dl_pkg::P1_ADDR_W-1:0]     p1_addr_o,
	output logic [15:0]                          p1_data_o,
	output logic                                 p2_req_o,
	input  logic                                 p2_ack_i,
	output logic [neo_dl_pkg::WORD_ADDR_W-1:0]   p2_addr_o,
	output logic [15:0]                          p2_data_o,
	output neo_dl_pkg::size_t                    c_mask_o,
	output neo_dl_pkg::size_t                    v1_mask_o,
	output neo_dl_pkg::size_t                    v2_mask_o,
	output neo_dl_pkg::size_t                    p2_mask_o,
	output logic                                 pcm_merged_o
);

	// Parser to shuffler
	logic [7:0]          b_data;
	logic                b_valid;
	logic                b_ready;
	neo_dl_pkg::region_e b_region;
	logic [ADDR_W-1:0]   b_offset;

	// Shuffler to mapper
	logic [15:0]         w_data;
	logic                w_valid;
	logic                w_ready;
	neo_dl_pkg::region_e w_region;
	logic [ADDR_W-1:0]   w_offset;

	neo_dl_pkg::size_t   csize;
	neo_dl_pkg::size_t   v1size;

	neo_header_parser #(
		.ADDR_W(ADDR_W)
	) neo_header_parser_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.byte_ready_o (byte_ready_o),
		.download_i   (download_i),
		.skip_adpcm_i (skip_adpcm_i),
		.b_data_o     (b_data),
		.b_valid_o    (b_valid),
		.b_ready_i    (b_ready),
		.b_region_o   (b_region),
		.b_offset_o   (b_offset),
		.csize_o      (csize),
		.v1size_o     (v1size),
		.c_mask_o     (c_mask_o),
		.v1_mask_o    (v1_mask_o),
		.v2_mask_o    (v2_mask_o),
		.p2_mask_o    (p2_mask_o),
		.pcm_merged_o (pcm_merged_o)
	);

	neo_tile_shuffler #(
		.ADDR_W     (ADDR_W),
		.PAGE_BYTES (PAGE_BYTES)
	) neo_tile_shuffler_i (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.b_data_i   (b_data),
		.b_valid_i  (b_valid),
		.b_ready_o  (b_ready),
		.b_region_i (b_region),
		.b_offset_i (b_offset),
		.w_data_o   (w_data),
		.w_valid_o  (w_valid),
		.w_ready_i  (w_ready),
		.w_region_o (w_region),
		.w_offset_o (w_offset)
	);

	neo_sdram_mapper #(
		.ADDR_W(ADDR_W)
	) neo_sdram_mapper_i (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.w_data_i   (w_data),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.w_region_i (w_region),
		.w_offset_i (w_offset),
		.csize_i    (csize),
		.v1size_i   (v1size),
		.p1_req_o   (p1_req_o),
		.p1_ack_i   (p1_ack_i),
		.p1_addr_o  (p1_addr_o),
		.p1_data_o  (p1_data_o),
		.p2_req_o   (p2_req_o),
		.p2_ack_i   (p2_ack_i),
		.p2_addr_o  (p2_addr_o),
		.p2_data_o  (p2_data_o)
	);

endmodule

`default_nettype wire

//--- sdram_port_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_port_model #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              req_i,
	output logic              ack_o,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [15:0]       data_i,
	output logic              wr_o,      // One cycle per completed write
	output logic [ADDR_W-1:0] wr_addr_o,
	output logic [15:0]       wr_data_o
);

	logic        busy_q;
	int unsigned wait_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ack_o     <= 1'b0;
			busy_q    <= 1'b0;
			wait_q    <= 0;
			wr_o      <= 1'b0;
			wr_addr_o <= '0;
			wr_data_o <= '0;
		end else begin
			wr_o <= 1'b0;
			if (!busy_q && req_i != ack_o) begin
				busy_q <= 1'b1;
				// Mostly short, now and then a long refresh-like stall
				wait_q <= ($urandom % 8 == 0) ? 20 + $urandom % 40 : $urandom % 4;
			end else if (busy_q) begin
				if (wait_q == 0) begin
					ack_o     <= req_i;
					busy_q    <= 1'b0;
					wr_o      <= 1'b1;
					wr_addr_o <= addr_i;
					wr_data_o <= data_i;
				end else begin
					wait_q <= wait_q - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- neo_cart_loader_tb.sv
`timescale 1ns/1ns
`default_nettype none

module neo_cart_loader_tb;

	localparam int MAX_TESTS = 16;
	localparam int COLS      = 11; // Six sizes, mode, four masks

	typedef struct packed {
		logic                               port; // 0 is port 1
		logic [neo_dl_pkg::WORD_ADDR_W-1:0] addr;
		logic [15:0]                        data;
	} word_t;

	logic                               CLK_48M;
	logic                               pll_locked;
	logic [7:0]                         byte_data;
	logic                               byte_valid, byte_ready, download, skip_adpcm;
	logic                               p1_req, p1_ack, p2_req, p2_ack;
	logic [neo_dl_pkg::P1_ADDR_W-1:0]   p1_addr, p1_wr_addr;
	logic [neo_dl_pkg::WORD_ADDR_W-1:0] p2_addr, p2_wr_addr;
	logic [15:0]                        p1_data, p2_data, p1_wr_data, p2_wr_data;
	logic                               p1_wr, p2_wr;
	neo_dl_pkg::size_t                  c_mask, v1_mask, v2_mask, p2_mask;
	logic                               pcm_merged;

	logic [31:0]       tests_mem [MAX_TESTS*COLS];
	neo_dl_pkg::size_t cur_size [6]; // P, S, M, V1, V2, C
	word_t             exp_q [$];
	int                num_tests;
	int                stall_cycles = 0;

	always #4 CLK_48M = ~CLK_48M;

	neo_cart_loader neo_cart_loader_i (
		.clk_i(CLK_48M), .rst_ni(pll_locked),
		.byte_i(byte_data), .byte_valid_i(byte_valid), .byte_ready_o(byte_ready),
		.download_i(download), .skip_adpcm_i(skip_adpcm),
		.p1_req_o(p1_req), .p1_ack_i(p1_ack), .p1_addr_o(p1_addr), .p1_data_o(p1_data),
		.p2_req_o(p2_req), .p2_ack_i(p2_ack), .p2_addr_o(p2_addr), .p2_data_o(p2_data),
		.c_mask_o(c_mask), .v1_mask_o(v1_mask), .v2_mask_o(v2_mask), .p2_mask_o(p2_mask),
		.pcm_merged_o(pcm_merged)
	);

	sdram_port_model #(.ADDR_W(neo_dl_pkg::P1_ADDR_W)) sdram_p1_i (
		.clk_i(CLK_48M), .rst_ni(pll_locked), .req_i(p1_req), .ack_o(p1_ack),
		.addr_i(p1_addr), .data_i(p1_data),
		.wr_o(p1_wr), .wr_addr_o(p1_wr_addr), .wr_data_o(p1_wr_data)
	);

	sdram_port_model #(.ADDR_W(neo_dl_pkg::WORD_ADDR_W)) sdram_p2_i (
		.clk_i(CLK_48M), .rst_ni(pll_locked), .req_i(p2_req), .ack_o(p2_ack),
		.addr_i(p2_addr), .data_i(p2_data),
		.wr_o(p2_wr), .wr_addr_o(p2_wr_addr), .wr_data_o(p2_wr_data)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input logic port, input logic [neo_dl_pkg::WORD_ADDR_W-1:0] addr,
		input logic [15:0] data);
		word_t exp;
		if (exp_q.size() == 0)
			fail_run($sformatf("Port %0d wrote address %h while no write was expected",
				port + 1, addr));
		exp = exp_q.pop_front();
		if (exp.port !== port || exp.addr !== addr || exp.data !== data)
			fail_run($sformatf("[FAIL] %0t ns: port %0d wrote %h at %h, expected port %0d %h at %h",
				$time, port + 1, data, addr, exp.port + 1, exp.data, exp.addr));
	endtask

	task automatic check_mask(input neo_dl_pkg::size_t got, input neo_dl_pkg::size_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic watchdog(input int unsigned limit);
		repeat (limit) @(posedge CLK_48M);
		fail_run($sformatf("Watchdog expired after %0d cycles, the loader stopped making progress",
			limit));
	endtask

	// Region numbers follow file order: P S M V1 V2 C
	function automatic logic [7:0] region_byte(input int r, input int off);
		return 8'(r * 37 + off);
	endfunction

	// Which region offset lands at this position of the reordered page
	function automatic int src_offset(input int r, input int off);
		logic [6:0] p;
		logic [6:0] a;
		p = 7'(off);
		case (r)
			1:       a = {p[6], p[5], ~p[1], p[0], p[4], p[3], p[2]};
			5:       a = {~p[2], p[6], p[5], p[4], p[3], p[0], p[1]};
			default: a = p;
		endcase
		return (off & ~127) | int'(a);
	endfunction

	function automatic logic [neo_dl_pkg::WORD_ADDR_W-1:0] word_addr(input int r, input int off);
		logic [31:0] byte_addr;
		case (r)
			1:       byte_addr = (32'h1C << 19) | (off & 32'h7FFFF); // FIX in bank 3
			2:       byte_addr = (32'h1E << 19) | (off & 32'h7FFFF); // Z80 ROM in bank 3
			3:       byte_addr = cur_size[5] + off;
			4:       byte_addr = cur_size[5] + cur_size[3] + off;
			default: byte_addr = off;
		endcase
		return neo_dl_pkg::WORD_ADDR_W'(byte_addr >> 1);
	endfunction

	function automatic logic [7:0] header_byte(input int a);
		neo_dl_pkg::size_t sz;
		if (a >= neo_dl_pkg::SIZE_FIELD_FIRST && a <= neo_dl_pkg::SIZE_FIELD_LAST) begin
			sz = cur_size[(a - 4) / 4];
			return sz[8*((a - 4) % 4) +: 8];
		end
		return 8'(a ^ (a >> 7));
	endfunction

	function automatic void build_expected(input logic skip);
		word_t w;
		exp_q.delete();
		for (int r = 0; r < 6; r++) begin
			if (skip && (r == 3 || r == 4))
				continue;
			for (int off = 0; off < int'(cur_size[r]); off += 2) begin
				w.port = r >= 3;
				w.addr = word_addr(r, off);
				w.data = {region_byte(r, src_offset(r, off + 1)), region_byte(r, src_offset(r, off))};
				exp_q.push_back(w);
			end
		end
	endfunction

	function automatic int unsigned stream_length(input int t);
		int unsigned n;
		n = neo_dl_pkg::HEADER_BYTES;
		if (tests_mem[t*COLS+6] != 2) begin
			for (int r = 0; r < 6; r++)
				n += tests_mem[t*COLS+r];
		end
		return n;
	endfunction

	// Called and returns 1 ns after a rising edge
	task automatic send_byte(input logic [7:0] value);
		int unsigned gap;
		gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
		if (gap != 0) begin
			byte_valid = 1'b0;
			repeat (gap) @(posedge CLK_48M);
			#1;
		end
		byte_data  = value;
		byte_valid = 1'b1;
		forever begin
			@(posedge CLK_48M);
			if (byte_ready)
				break;
		end
		#1;
	endtask

	task automatic run_test(input int t);
		int unsigned mode;
		for (int r = 0; r < 6; r++)
			cur_size[r] = tests_mem[t*COLS+r];
		mode = tests_mem[t*COLS+6]; // 0 full, 1 skip ADPCM, 2 header only
		if (mode != 2)
			build_expected(mode == 1);
		else
			exp_q.delete();
		skip_adpcm = mode == 1;
		download   = 1'b1;
		for (int a = 0; a < neo_dl_pkg::HEADER_BYTES; a++)
			send_byte(header_byte(a));
		if (mode != 2) begin
			for (int r = 0; r < 6; r++)
				for (int off = 0; off < int'(cur_size[r]); off++)
					send_byte(region_byte(r, off));
		end
		byte_valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge CLK_48M);
		@(posedge CLK_48M);
		#1;
		check_mask(c_mask, tests_mem[t*COLS+7], "C mask");
		check_mask(v1_mask, tests_mem[t*COLS+8], "V1 mask");
		check_mask(v2_mask, tests_mem[t*COLS+9], "V2 mask");
		check_mask(p2_mask, tests_mem[t*COLS+10], "P2 mask");
		check_flag(pcm_merged, cur_size[4] == '0, "pcm_merged");
		download   = 1'b0;
		skip_adpcm = 1'b0;
		repeat (4) @(posedge CLK_48M);
		#1;
	endtask

	always @(posedge CLK_48M) begin
		if (p1_wr)
			check_word(1'b0, neo_dl_pkg::WORD_ADDR_W'(p1_wr_addr), p1_wr_data);
		if (p2_wr)
			check_word(1'b1, p2_wr_addr, p2_wr_data);
		if (download && byte_valid && !byte_ready)
			stall_cycles++;
	end

	initial begin
		int unsigned total_bytes;
		void'($urandom(32'h60a1_b27e));
		CLK_48M    = 1'b0;
		pll_locked = 1'b0;
		byte_data  = '0;
		byte_valid = 1'b0;
		download   = 1'b0;
		skip_adpcm = 1'b0;
		for (int i = 0; i < MAX_TESTS * COLS; i++)
			tests_mem[i] = '1; // End marker
		$readmemh("neo_cart_tests.txt", tests_mem);
		num_tests   = 0;
		total_bytes = 0;
		while (num_tests < MAX_TESTS && tests_mem[num_tests*COLS] != '1) begin
			total_bytes += stream_length(num_tests);
			num_tests++;
		end
		if (num_tests == 0)
			fail_run("No tests were found in neo_cart_tests.txt");
		fork
			watchdog(40 * total_bytes + 1000);
		join_none
		repeat (10) @(posedge CLK_48M);
		#1;
		pll_locked = 1'b1;
		check_flag(byte_ready, 1'b1, "byte_ready_o after reset");
		check_flag(p1_req == p1_ack, 1'b1, "port 1 idle after reset");
		check_flag(p2_req == p2_ack, 1'b1, "port 2 idle after reset");
		check_mask(c_mask | v1_mask | v2_mask | p2_mask, '0, "masks after reset");
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		if (stall_cycles == 0)
			fail_run("byte_ready_o never dropped, back-pressure was not exercised");
		else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- neo_cart_tests.txt
// PSIZE SSIZE MSIZE V1SIZE V2SIZE CSIZE MODE(0 full, 1 skip ADPCM, 2 header only)
// then the expected C_MASK V1_MASK V2_MASK P2_MASK, all hex
00000400 00000200 00000100 00000180 00000080 00000300 0 000003FF 000001FF 0000007F 00000000
00000200 00000000 00000080 00000100 00000000 00000200 0 000001FF 000000FF 00000000 00000000
00000100 00000100 00000000 00000200 00000180 00000100 1 000000FF 000001FF 000001FF 00000000
00180000 00020000 00020000 00400000 00400000 01000000 2 00FFFFFF 003FFFFF 003FFFFF 0007FFFF
00000080 00000080 00000080 00000000 00000000 00000400 0 000003FF 00000000 00000000 00000000
00000000 00000000 00000000 00000080 00000080 00000000 0 00000000 0000007F 0000007F 00000000

//--- all.f
neo_dl_pkg.sv
neo_header_parser.sv
neo_tile_shuffler.sv
neo_sdram_mapper.sv
neo_cart_loader.sv
sdram_port_model.sv
neo_cart_loader_tb.sv

//--- Bender.yml
package:
  name: neo_cart_loader

sources:
  - neo_dl_pkg.sv
  - neo_header_parser.sv
  - neo_tile_shuffler.sv
  - neo_sdram_mapper.sv
  - neo_cart_loader.sv
  - target: test
    files:
      - sdram_port_model.sv
      - neo_cart_loader_tb.sv
